// File: common/ipv4_rw_params.svh
/* IPv4 rewrite header layout */

`ifndef IPV4_RW_PARAMS_SVH
`define IPV4_RW_PARAMS_SVH

`default_nettype none

// Plain 20-byte header as 16-bit words, no options
`define IPV4_RW_HDR_WORDS 4'd10

// Word positions of the touched fields
`define IPV4_RW_TOS_WORD  4'd0      // Version, IHL, DSCP, ECN
`define IPV4_RW_TTL_WORD  4'd4      // TTL upper byte, protocol lower
`define IPV4_RW_CSUM_WORD 4'd5      // Header checksum

`default_nettype wire

`endif

// File: common/ipv4_rw_pkg.sv
/* IPv4 header rewrite types */

`default_nettype none

package ipv4_rw_pkg;

    ////////////////////////////////////////////////////////////
    // Stream and field types

    typedef logic [15:0] hdr_word_t;    // One header word on the stream
    typedef logic [15:0] csum_t;        // Ones' complement checksum or field sum
    typedef logic [3:0]  word_idx_t;    // Word position, saturates at 15
    typedef logic [5:0]  dscp_t;        // DSCP code point

    ////////////////////////////////////////////////////////////
    // Ones' complement arithmetic

    // 16-bit add with end-around carry
    function automatic csum_t ones_add(input csum_t a, input csum_t b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        // Carry wraps into bit 0, never overflows twice
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

`default_nettype wire

// File: hdl/ipv4_checksum_update.sv
/* RFC 1624 incremental checksum update */

`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_update (
    input  logic               update_req,          // Clock
    input  logic               arst_n,
    input  logic               csum_req_valid,      // One request per header
    input  ipv4_rw_pkg::csum_t csum_req_old,        // Checksum as received
    input  ipv4_rw_pkg::csum_t csum_req_old_field,  // Sum of old fields
    input  ipv4_rw_pkg::csum_t csum_req_new_field,  // Sum of new fields
    output logic               csum_valid,
    output ipv4_rw_pkg::csum_t new_csum
);

    ////////////////////////////////////////////////////////////
    // Equation 3, HC' = ~(~HC + ~m + m')

    ipv4_rw_pkg::csum_t partial_sum;    // ~HC + ~m
    ipv4_rw_pkg::csum_t full_sum;       // Plus m'
    ipv4_rw_pkg::csum_t new_csum_comb;

    assign partial_sum   = ipv4_rw_pkg::ones_add(~csum_req_old, ~csum_req_old_field);
    assign full_sum      = ipv4_rw_pkg::ones_add(partial_sum, csum_req_new_field);
    assign new_csum_comb = ~full_sum;   // Back to checksum form

    ////////////////////////////////////////////////////////////
    // Result register, one clock after request

    always_ff @(posedge update_req or negedge arst_n) begin
        if (!arst_n) begin
            csum_valid <= 1'b0;
        end else begin
            csum_valid <= csum_req_valid;   // Strobe follows request
        end
    end

    // Hold last value between requests
    always_ff @(posedge update_req) begin
        if (csum_req_valid) begin
            new_csum <= new_csum_comb;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ipv4_field_rewrite.sv
/* IPv4 TTL and DSCP field rewrite */

`timescale 1ns/1ps
`include "ipv4_rw_params.svh"
`default_nettype none

module ipv4_field_rewrite (
    input  logic                   update_req,          // Clock
    input  logic                   arst_n,
    // Input header stream
    input  logic                   in_valid,
    input  logic                   in_sof,              // Word 0 marker
    input  ipv4_rw_pkg::hdr_word_t in_data,
    // Remark config, sampled on word 0
    input  logic                   dscp_remark_en,
    input  ipv4_rw_pkg::dscp_t     dscp_value,
    // Folded checksum update request
    output logic                   csum_req_valid,
    output ipv4_rw_pkg::csum_t     csum_req_old,
    output ipv4_rw_pkg::csum_t     csum_req_old_field,
    output ipv4_rw_pkg::csum_t     csum_req_new_field,
    // Updated checksum, aligned with output word 5
    input  logic                   csum_valid,
    input  ipv4_rw_pkg::csum_t     new_csum,
    // Rewritten stream
    output logic                   out_valid,
    output logic                   out_sof,
    output ipv4_rw_pkg::hdr_word_t out_data,
    output logic                   ttl_expired          // Pulse on output word 4
);

    localparam ipv4_rw_pkg::word_idx_t IDX_SAT = 4'd15;

    ipv4_rw_pkg::word_idx_t word_idx;   // Index expected for next word
    ipv4_rw_pkg::word_idx_t cur_idx;    // Index of word on in_data
    logic                   is_tos;
    logic                   is_ttl;
    logic                   is_csum;
    logic [7:0]             ttl;
    logic                   ttl_zero;
    ipv4_rw_pkg::hdr_word_t tos_new;
    ipv4_rw_pkg::hdr_word_t ttl_new;
    ipv4_rw_pkg::hdr_word_t word_new;   // Word as it leaves
    ipv4_rw_pkg::hdr_word_t tos_old_q;
    ipv4_rw_pkg::hdr_word_t tos_new_q;
    ipv4_rw_pkg::hdr_word_t ttl_old_q;
    ipv4_rw_pkg::hdr_word_t ttl_new_q;
    ipv4_rw_pkg::hdr_word_t data_q;

    ////////////////////////////////////////////////////////////
    // Word counter

    // SOF forces index 0 even mid-header
    assign cur_idx = in_sof ? '0 : word_idx;

    always_ff @(posedge update_req or negedge arst_n) begin
        if (!arst_n) begin
            word_idx <= IDX_SAT;                // Idle until first SOF
        end else if (in_valid) begin
            if (cur_idx < `IPV4_RW_HDR_WORDS - 4'd1) begin
                word_idx <= cur_idx + 4'd1;
            end else begin
                word_idx <= IDX_SAT;            // Past header, options pass through
            end
        end
    end

    assign is_tos  = (cur_idx == `IPV4_RW_TOS_WORD);
    assign is_ttl  = (cur_idx == `IPV4_RW_TTL_WORD);
    assign is_csum = (cur_idx == `IPV4_RW_CSUM_WORD);

    ////////////////////////////////////////////////////////////
    // Field rewrite

    assign ttl      = in_data[15:8];
    assign ttl_zero = (ttl == 8'd0);

    // Keep version, IHL and ECN
    assign tos_new = dscp_remark_en ? {in_data[15:8], dscp_value, in_data[1:0]} : in_data;
    assign ttl_new = ttl_zero ? in_data : {ttl - 8'd1, in_data[7:0]};  // No wrap below zero

    always_comb begin
        word_new = in_data;
        if (is_tos) begin
            word_new = tos_new;
        end else if (is_ttl) begin
            word_new = ttl_new;
        end
    end

    // Old and new field words for the update fold
    always_ff @(posedge update_req) begin
        if (in_valid && is_tos) begin
            tos_old_q <= in_data;
            tos_new_q <= tos_new;
        end
        if (in_valid && is_ttl) begin
            ttl_old_q <= in_data;
            ttl_new_q <= ttl_new;
        end
    end

    ////////////////////////////////////////////////////////////
    // Update request, both fields folded into one

    assign csum_req_valid     = in_valid & is_csum;
    assign csum_req_old       = in_data;                // Checksum word itself
    assign csum_req_old_field = ipv4_rw_pkg::ones_add(tos_old_q, ttl_old_q);
    assign csum_req_new_field = ipv4_rw_pkg::ones_add(tos_new_q, ttl_new_q);

    ////////////////////////////////////////////////////////////
    // Output stage

    always_ff @(posedge update_req or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            out_sof     <= 1'b0;
            ttl_expired <= 1'b0;
        end else begin
            out_valid   <= in_valid;                     // Gaps kept as is
            out_sof     <= in_valid & in_sof;
            ttl_expired <= in_valid & is_ttl & ttl_zero;
        end
    end

    always_ff @(posedge update_req) begin
        if (in_valid) begin
            data_q <= word_new;
        end
    end

    // Checksum result lands with word 5
    assign out_data = csum_valid ? new_csum : data_q;

endmodule

`default_nettype wire

// File: hdl/ipv4_hdr_rewrite_top.sv
/* IPv4 header rewrite top */

`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_rewrite_top (
    input  logic                   update_req,      // Clock
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic                   in_sof,
    input  ipv4_rw_pkg::hdr_word_t in_data,
    input  logic                   dscp_remark_en,
    input  ipv4_rw_pkg::dscp_t     dscp_value,
    output logic                   out_valid,
    output logic                   out_sof,
    output ipv4_rw_pkg::hdr_word_t out_data,
    output logic                   ttl_expired
);

    ////////////////////////////////////////////////////////////
    // Request and result between the two stages

    logic               csum_req_valid;
    ipv4_rw_pkg::csum_t csum_req_old;
    ipv4_rw_pkg::csum_t csum_req_old_field;
    ipv4_rw_pkg::csum_t csum_req_new_field;
    logic               csum_valid;
    ipv4_rw_pkg::csum_t new_csum;

    // Stream path, counts words and rewrites fields
    ipv4_field_rewrite ipv4_field_rewrite_inst (
        .update_req         (update_req),
        .arst_n             (arst_n),
        .in_valid           (in_valid),
        .in_sof             (in_sof),
        .in_data            (in_data),
        .dscp_remark_en     (dscp_remark_en),
        .dscp_value         (dscp_value),
        .csum_req_valid     (csum_req_valid),
        .csum_req_old       (csum_req_old),
        .csum_req_old_field (csum_req_old_field),
        .csum_req_new_field (csum_req_new_field),
        .csum_valid         (csum_valid),
        .new_csum           (new_csum),
        .out_valid          (out_valid),
        .out_sof            (out_sof),
        .out_data           (out_data),
        .ttl_expired        (ttl_expired)
    );

    // One request per header, answered next clock
    ipv4_checksum_update ipv4_checksum_update_inst (
        .update_req         (update_req),
        .arst_n             (arst_n),
        .csum_req_valid     (csum_req_valid),
        .csum_req_old       (csum_req_old),
        .csum_req_old_field (csum_req_old_field),
        .csum_req_new_field (csum_req_new_field),
        .csum_valid         (csum_valid),
        .new_csum           (new_csum)
    );

endmodule

`default_nettype wire

// File: dv/ipv4_hdr_rewrite_assert.sv
/* Header rewrite timing assertions */

`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_rewrite_assert (
    input logic update_req,     // Clock
    input logic arst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_sof,
    input logic ttl_expired
);

    int fail_count = 0;         // Read by the testbench at the end

    // Outputs quiet while reset is applied
    reset_quiet: assert property (@(posedge update_req)
        !arst_n |-> (!out_valid && !ttl_expired))
        else begin
            $error("out_valid or ttl_expired high during reset");
            fail_count++;
        end

    // Each input word shows up exactly one clock later
    one_clock_delay: assert property (@(posedge update_req) disable iff (!arst_n)
        out_valid == $past(in_valid))
        else begin
            $error("out_valid does not follow in_valid by one clock");
            fail_count++;
        end

    sof_with_valid: assert property (@(posedge update_req) disable iff (!arst_n)
        out_sof |-> out_valid)
        else begin
            $error("out_sof high without out_valid");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: dv/ipv4_hdr_rewrite_checker.sv
/* Header rewrite reference checker */

`timescale 1ns/1ps
`include "ipv4_rw_params.svh"
`default_nettype none

module ipv4_hdr_rewrite_checker (
    input  logic                   update_req,      // Clock
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic                   in_sof,
    input  ipv4_rw_pkg::hdr_word_t in_data,
    input  logic                   dscp_remark_en,
    input  ipv4_rw_pkg::dscp_t     dscp_value,
    input  logic                   out_valid,
    input  logic                   out_sof,
    input  ipv4_rw_pkg::hdr_word_t out_data,
    input  logic                   ttl_expired,
    output int                     mismatch_count,
    output int                     other_count,
    output int                     hdr_count        // Headers fully compared
);

    localparam int WORDS  = int'(`IPV4_RW_HDR_WORDS);
    localparam int TOS_W  = int'(`IPV4_RW_TOS_WORD);
    localparam int TTL_W  = int'(`IPV4_RW_TTL_WORD);
    localparam int CSUM_W = int'(`IPV4_RW_CSUM_WORD);

    logic [16*WORDS-1:0] in_hdr;        // Word i at [16*i +: 16]
    logic [16*WORDS-1:0] out_hdr;
    logic                cap_remark;    // Config seen with word 0
    ipv4_rw_pkg::dscp_t  cap_dscp;
    int                  in_idx = WORDS;    // WORDS means outside a header
    int                  out_idx = WORDS;
    int                  cycle = 0;
    int                  in_time [WORDS];   // Cycle each input word was taken
    int                  mismatches = 0;
    int                  others = 0;
    int                  headers = 0;

    assign mismatch_count = mismatches;
    assign other_count    = others;
    assign hdr_count      = headers;

    ////////////////////////////////////////////////////////////
    // Reference, TTL and DSCP rules then full checksum

    function automatic logic [16*WORDS-1:0] expected_header(input logic [16*WORDS-1:0] hdr,
                                                             input logic remark,
                                                             input ipv4_rw_pkg::dscp_t dscp);
        logic [16*WORDS-1:0] exp_hdr;
        logic [7:0]          ttl;
        logic [31:0]         acc;
        int                  i;
        exp_hdr = hdr;
        ttl = hdr[16*TTL_W+8 +: 8];
        if (ttl != 8'd0) begin
            exp_hdr[16*TTL_W+8 +: 8] = ttl - 8'd1;   // Zero TTL left alone
        end
        if (remark) begin
            exp_hdr[16*TOS_W+2 +: 6] = dscp;        // ECN bits kept
        end
        exp_hdr[16*CSUM_W +: 16] = 16'h0000;        // Checksum counts as zero
        acc = 32'd0;
        for (i = 0; i < WORDS; i++) begin
            acc = acc + {16'h0000, exp_hdr[16*i +: 16]};
        end
        while (acc[31:16] != 16'h0000) begin
            acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};  // End-around carry
        end
        exp_hdr[16*CSUM_W +: 16] = ~acc[15:0];
        return exp_hdr;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare on every rising edge

    always @(posedge update_req) begin : compare
        logic [16*WORDS-1:0] exp_hdr;
        logic                exp_pulse;
        int                  i;
        cycle = cycle + 1;
        exp_pulse = 1'b0;
        if (!arst_n) begin
            if (out_valid || ttl_expired) begin
                others++;
                $display("Output active during reset at cycle %0d", cycle);
            end
            in_idx = WORDS;
            out_idx = WORDS;
        end else begin
            // Output side first, the next header may start on this edge
            if (out_valid) begin
                if (out_sof) begin
                    out_idx = 0;
                end
                if (out_idx >= WORDS) begin
                    others++;
                    $display("Output word outside any header at cycle %0d", cycle);
                end else begin
                    if (cycle != in_time[out_idx] + 1) begin
                        others++;
                        $display("Output word %0d came %0d clocks after its input instead of 1",
                                 out_idx, cycle - in_time[out_idx]);
                    end
                    exp_pulse = (out_idx == TTL_W) && (in_hdr[16*TTL_W+8 +: 8] == 8'd0);
                    out_hdr[16*out_idx +: 16] = out_data;
                    if (out_idx == WORDS - 1) begin
                        exp_hdr = expected_header(in_hdr, cap_remark, cap_dscp);
                        for (i = 0; i < WORDS; i++) begin
                            if (out_hdr[16*i +: 16] !== exp_hdr[16*i +: 16]) begin
                                mismatches++;
                                $display("Mismatch out_data header %0d word %0d: got %h expected %h",
                                         headers, i, out_hdr[16*i +: 16], exp_hdr[16*i +: 16]);
                            end
                        end
                        headers++;
                    end
                    out_idx++;
                end
            end
            if (ttl_expired !== exp_pulse) begin
                mismatches++;
                $display("Mismatch ttl_expired at cycle %0d: got %h expected %h",
                         cycle, ttl_expired, exp_pulse);
            end
            // Input capture
            if (in_valid) begin
                if (in_sof) begin
                    in_idx = 0;
                    cap_remark = dscp_remark_en;
                    cap_dscp = dscp_value;
                end
                if (in_idx < WORDS) begin
                    in_hdr[16*in_idx +: 16] = in_data;
                    in_time[in_idx] = cycle;
                    in_idx++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/ipv4_hdr_rewrite_tb.sv
/* IPv4 header rewrite testbench */

`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_rewrite_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int DIRECT_HDRS     = 4;
    localparam int GAP_HDRS        = 12;
    localparam int B2B_HDRS        = 12;
    localparam int N_HDRS          = DIRECT_HDRS + GAP_HDRS + B2B_HDRS;
    localparam int WATCHDOG_CYCLES = N_HDRS * 20 + 200;

    logic                   update_req = 1'b0;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_sof;
    ipv4_rw_pkg::hdr_word_t in_data;
    logic                   dscp_remark_en;
    ipv4_rw_pkg::dscp_t     dscp_value;
    logic                   out_valid;
    logic                   out_sof;
    ipv4_rw_pkg::hdr_word_t out_data;
    logic                   ttl_expired;
    integer                 seed;
    int                     mismatch_count;
    int                     other_count;
    int                     hdr_count;

    always #(CLK_PERIOD / 2) update_req = ~update_req;

    ipv4_hdr_rewrite_top ipv4_hdr_rewrite_top_inst (
        .update_req     (update_req),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_sof         (in_sof),
        .in_data        (in_data),
        .dscp_remark_en (dscp_remark_en),
        .dscp_value     (dscp_value),
        .out_valid      (out_valid),
        .out_sof        (out_sof),
        .out_data       (out_data),
        .ttl_expired    (ttl_expired)
    );

    ipv4_hdr_rewrite_checker ipv4_hdr_rewrite_checker_inst (
        .update_req     (update_req),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_sof         (in_sof),
        .in_data        (in_data),
        .dscp_remark_en (dscp_remark_en),
        .dscp_value     (dscp_value),
        .out_valid      (out_valid),
        .out_sof        (out_sof),
        .out_data       (out_data),
        .ttl_expired    (ttl_expired),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .hdr_count      (hdr_count)
    );

    bind ipv4_hdr_rewrite_top ipv4_hdr_rewrite_assert ipv4_hdr_rewrite_assert_inst (
        .update_req  (update_req),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .out_valid   (out_valid),
        .out_sof     (out_sof),
        .ttl_expired (ttl_expired)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Random 20-byte header with a valid checksum
    function automatic logic [159:0] random_header(input logic [7:0] ttl);
        logic [159:0] hdr;
        logic [31:0]  r;
        logic [31:0]  acc;
        int           i;
        for (i = 0; i < 10; i++) begin
            r = next_rand();
            hdr[16*i +: 16] = r[15:0];
        end
        hdr[15:8]  = 8'h45;         // Version 4, IHL 5
        hdr[79:72] = ttl;           // Word 4 upper byte
        hdr[95:80] = 16'h0000;      // Word 5 zero while summing
        acc = 32'd0;
        for (i = 0; i < 10; i++) begin
            acc = acc + {16'h0000, hdr[16*i +: 16]};
        end
        while (acc[31:16] != 16'h0000) begin
            acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        end
        hdr[95:80] = ~acc[15:0];
        return hdr;
    endfunction

    task automatic send_header(input logic [159:0] hdr, input logic remark,
                               input ipv4_rw_pkg::dscp_t dscp, input logic with_gaps);
        logic [31:0] r;
        int          i;
        for (i = 0; i < 10; i++) begin
            @(negedge update_req);
            r = next_rand();
            in_valid = 1'b1;
            in_sof   = (i == 0);
            in_data  = hdr[16*i +: 16];
            if (i == 0) begin
                dscp_remark_en = remark;
                dscp_value     = dscp;
            end else begin
                dscp_remark_en = r[16];     // Ignored after word 0
                dscp_value     = r[22:17];
            end
            if (with_gaps && r[0]) begin
                @(negedge update_req);
                in_valid = 1'b0;
                in_sof   = 1'b0;
                in_data  = r[31:16];        // Junk on idle cycle
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] r;
        int          n;
        int          errors;
        seed           = 83123;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_sof         = 1'b0;
        in_data        = 16'h0000;
        dscp_remark_en = 1'b0;
        dscp_value     = 6'h00;
        // Words offered during reset, zero TTL throughout
        for (n = 0; n < 6; n++) begin
            @(negedge update_req);
            in_valid = 1'b1;
            in_sof   = (n == 0);
        end
        @(negedge update_req);
        in_valid = 1'b0;                // Idle on the last reset edge
        in_sof   = 1'b0;
        @(negedge update_req);
        arst_n = 1'b1;
        // TTL decrement, zero TTL, remark with both TTL cases
        send_header(random_header(8'd64), 1'b0, 6'h2e, 1'b0);
        send_header(random_header(8'd0), 1'b0, 6'h2e, 1'b0);
        send_header(random_header(8'd1), 1'b1, 6'h2e, 1'b0);
        send_header(random_header(8'd0), 1'b1, 6'h0a, 1'b0);
        for (n = 0; n < GAP_HDRS; n++) begin
            r = next_rand();
            send_header(random_header(r[9:8] == 2'b00 ? 8'd0 : r[23:16]), r[4], r[15:10], 1'b1);
        end
        for (n = 0; n < B2B_HDRS; n++) begin
            r = next_rand();
            send_header(random_header(r[9:8] == 2'b00 ? 8'd0 : r[23:16]), r[4], r[15:10], 1'b0);
        end
        @(negedge update_req);
        in_valid = 1'b0;
        in_sof   = 1'b0;
        repeat (4) @(negedge update_req);   // Drain last word
        errors = mismatch_count + other_count
               + ipv4_hdr_rewrite_top_inst.ipv4_hdr_rewrite_assert_inst.fail_count;
        if (hdr_count != N_HDRS) begin
            $display("Not every header sent came out of the DUT");
        end
        $display("Errors: mismatch %0d, other %0d, assertion %0d; headers checked %0d of %0d",
                 mismatch_count, other_count,
                 ipv4_hdr_rewrite_top_inst.ipv4_hdr_rewrite_assert_inst.fail_count,
                 hdr_count, N_HDRS);
        if (errors == 0 && hdr_count == N_HDRS) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, stimulus did not finish", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/ipv4_rw_pkg.sv
hdl/ipv4_checksum_update.sv
hdl/ipv4_field_rewrite.sv
hdl/ipv4_hdr_rewrite_top.sv
dv/ipv4_hdr_rewrite_assert.sv
dv/ipv4_hdr_rewrite_checker.sv
dv/ipv4_hdr_rewrite_tb.sv

// File: Makefile
# Verilator build and run of the IPv4 header rewrite testbench

TOP := ipv4_hdr_rewrite_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove obj_dir and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
